//--- Bender.yml
package:
  name: mips_front_end

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_fe_pkg.sv
      - hdl/instr_mem.sv
      - hdl/reg_file.sv
      - hdl/fetch_stage.sv
      - hdl/branch_resolve.sv
      - hdl/credit_tracker.sv
      - hdl/mips_front_end.sv
  - target: simulation
    include_dirs:
      - hdl
      - bench
    files:
      - bench/tb_mips_front_end.sv

//--- bench/tb_fe_model.svh
`ifndef TB_FE_MODEL_SVH
`define TB_FE_MODEL_SVH

localparam int NB_WORDS = 1 << `FE_IMEM_DEPTH;

word_t prog_mem [NB_WORDS];   // Copy of what was loaded into the RAM
word_t ref_regs [32];         // Register file as seen by decode
pc_t   exp_pc [$];            // Expected pc+4 per output beat
word_t exp_instr [$];

// 32-bit LCG step
function automatic logic [31:0] lcg_step(input logic [31:0] state);
   return state * 32'd1664525 + 32'd1013904223;
endfunction

// Random program whose control flow only moves forward modulo the RAM size
function automatic logic [31:0] build_program(input logic [31:0] seed);
   logic [31:0] s;
   logic [15:0] br_imm;
   word_t       word;
   s = seed;
   for (int i = 0; i < NB_WORDS; i++) begin
      s      = lcg_step(s);
      br_imm = {{10{s[12]}}, 3'd0, s[15:13]};  // 0 to 7 words, or that less one RAM span
      case (s[31:29])
         3'd4:    word = {OP_BEQ, 2'b00, s[22:20], 2'b00, s[18:16], br_imm};
         3'd5:    word = {OP_BNE, 2'b00, s[22:20], 2'b00, s[18:16], br_imm};
         3'd6:    word = {OP_J, 20'd0, 6'(i + 2 + s[3:0])};  // 2 to 17 words ahead
         default: word = {6'h00, s[25:11], 5'h00, 6'h20};    // add rd, rs, rt
      endcase
      prog_mem[i] = word;
   end
   return s;
endfunction

// Walks the program the way the front end should issue it
function automatic void build_expected(input int nb_beats);
   pc_t   pc;
   pc_t   seq;                // Fall-through address
   pc_t   target;
   word_t instr;
   word_t rs_val;
   word_t rt_val;
   logic  taken;
   pc = '0;
   exp_pc.delete();
   exp_instr.delete();
   while (exp_pc.size() < nb_beats) begin
      instr  = prog_mem[pc[`FE_IMEM_DEPTH+1:2]];  // Index wraps
      seq    = pc + 32'd4;
      rs_val = ref_regs[instr[25:21]];
      rt_val = ref_regs[instr[20:16]];
      exp_pc.push_back(seq);
      exp_instr.push_back(instr);
      taken  = 1'b0;
      target = seq + {{(`FE_NB_BITS-18){instr[15]}}, instr[15:0], 2'b00};
      case (instr[31:26])
         OP_BEQ: taken = (rs_val == rt_val);
         OP_BNE: taken = (rs_val != rt_val);
         OP_J: begin
            taken  = 1'b1;
            target = {seq[31:28], instr[25:0], 2'b00};
         end
         default: taken = 1'b0;
      endcase
      if (taken) begin
         if (exp_pc.size() < nb_beats) begin
            exp_pc.push_back(seq + 32'd4);       // Killed slot keeps its own pc+4
            exp_instr.push_back(`FE_NOP_WORD);
         end
         pc = target;
      end else begin
         pc = seq;
      end
   end
endfunction

task automatic compare_pc(input int beat, input pc_t got, input pc_t want);
   if (got !== want) begin
      abort_run($sformatf("FAIL at %0t: beat %0d pc %h, expected %h", $time, beat, got, want));
   end
endtask

task automatic compare_instr(input int beat, input word_t got, input word_t want);
   if (got !== want) begin
      abort_run($sformatf("FAIL at %0t: beat %0d instr %h, expected %h",
                          $time, beat, got, want));
   end
endtask

`endif

//--- bench/tb_mips_front_end.sv
`include "mips_fe_cfg.svh"

module tb_mips_front_end
   import mips_fe_pkg::*;
();

   localparam int          NB_RUNS      = 2;     // Second run reloads everything
   localparam int          NB_BEATS     = 240;
   localparam int          RST_CYCLES   = 16;
   localparam int          BEAT_TIMEOUT = 300;   // Well above the longest credit pause
   localparam int          GO_TIMEOUT   = 2000;
   localparam int          RUN_TIMEOUT  = NB_BEATS * BEAT_TIMEOUT;
   localparam logic [31:0] SEED         = 32'h1eab_f96b;

   logic       i_clk;
   logic       i_rst;
   logic       i_run;
   logic       i_load_en;
   imem_addr_t i_load_addr;
   word_t      i_load_data;
   logic       i_wb_en;
   reg_addr_t  i_wb_addr;
   word_t      i_wb_data;
   logic       i_credit_ret;
   logic       o_out_valid;
   pc_t        o_out_pc;
   word_t      o_out_instr;

   int          runs_started;   // Expected queues ready
   int          runs_checked;
   logic [31:0] stim_seed;
   logic [31:0] credit_seed;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

`include "tb_fe_model.svh"

   always #5 i_clk = ~i_clk;

   mips_front_end mips_front_end_i (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_run        (i_run),
      .i_load_en    (i_load_en),
      .i_load_addr  (i_load_addr),
      .i_load_data  (i_load_data),
      .i_wb_en      (i_wb_en),
      .i_wb_addr    (i_wb_addr),
      .i_wb_data    (i_wb_data),
      .i_credit_ret (i_credit_ret),
      .o_out_valid  (o_out_valid),
      .o_out_pc     (o_out_pc),
      .o_out_instr  (o_out_instr)
   );

   // Reset also clears the register model like the RTL array
   task automatic apply_reset();
      i_rst = 1'b1;
      i_run = 1'b0;
      repeat (RST_CYCLES) @(negedge i_clk);
      i_rst = 1'b0;
      foreach (ref_regs[i]) begin
         ref_regs[i] = '0;
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input word_t data);
      i_wb_en   = 1'b1;
      i_wb_addr = addr;
      i_wb_data = data;
      if (addr != '0) begin
         ref_regs[addr] = data;   // $0 stays zero
      end
      @(negedge i_clk);
      i_wb_en = 1'b0;
   endtask

   task automatic load_word(input imem_addr_t addr, input word_t data);
      i_load_en   = 1'b1;
      i_load_addr = addr;
      i_load_data = data;
      @(negedge i_clk);
      i_load_en = 1'b0;
   endtask

   initial begin : main_flow
      int wait_cnt;
      i_clk       = 1'b0;
      i_rst       = 1'b1;
      i_run       = 1'b0;
      i_load_en   = 1'b0;
      i_load_addr = '0;
      i_load_data = '0;
      i_wb_en     = 1'b0;
      i_wb_addr   = '0;
      i_wb_data   = '0;
      stim_seed   = SEED;
      for (int r = 0; r < NB_RUNS; r++) begin
         apply_reset();
         for (int a = 0; a < 32; a++) begin
            stim_seed = lcg_step(stim_seed);
            // Later runs keep some registers at their reset value
            if ((r == 0) || stim_seed[30]) begin
               write_reg(reg_addr_t'(a), stim_seed);
            end
         end
         // Equal pairs so beq and bne both go either way
         write_reg(5'd2, ref_regs[1]);
         write_reg(5'd6, ref_regs[5]);
         write_reg(5'd3, '0);
         stim_seed = build_program(stim_seed);
         for (int w = 0; w < NB_WORDS; w++) begin
            load_word(imem_addr_t'(w), prog_mem[w]);
         end
         build_expected(NB_BEATS);
         runs_started++;
         @(negedge i_clk);       // One spare cycle for the checker to arm
         i_run = 1'b1;
         wait_cnt = 0;
         while (runs_checked <= r) begin
            @(negedge i_clk);
            wait_cnt++;
            if (wait_cnt > RUN_TIMEOUT) begin
               abort_run($sformatf("Timeout in run %0d, the stream never completed", r));
            end
         end
         i_run = 1'b0;
      end
      $display("Result: PASSED");
      $finish;
   end

   // In-order check of every issued beat
   initial begin : compare_stream
      int    wait_cnt;
      pc_t   want_pc;
      word_t want_instr;
      for (int r = 0; r < NB_RUNS; r++) begin
         wait_cnt = 0;
         while (runs_started <= r) begin
            @(negedge i_clk);
            wait_cnt++;
            if (wait_cnt > GO_TIMEOUT) begin
               abort_run($sformatf("Timeout, run %0d was never started", r));
            end
         end
         for (int b = 0; b < NB_BEATS; b++) begin
            wait_cnt = 0;
            @(negedge i_clk);
            while (o_out_valid !== 1'b1) begin
               wait_cnt++;
               if (wait_cnt > BEAT_TIMEOUT) begin
                  abort_run($sformatf("Timeout at %0t waiting for beat %0d", $time, b));
               end
               @(negedge i_clk);
            end
            want_pc    = exp_pc.pop_front();
            want_instr = exp_instr.pop_front();
            compare_pc(b, o_out_pc, want_pc);
            compare_instr(b, o_out_instr, want_instr);
         end
         runs_checked++;
      end
   end

   // Downstream model returning credits with random pauses
   initial begin : credit_return
      int          outstanding;  // Consumed and not yet returned
      int          gap;
      logic        beat;
      logic        beat_q;
      logic        ret_q;
      logic        in_rst;
      logic [31:0] draw;
      i_credit_ret = 1'b0;
      outstanding  = 0;
      gap          = 0;
      beat_q       = 1'b0;
      ret_q        = 1'b0;
      credit_seed  = lcg_step(SEED);
      forever begin
         @(posedge i_clk);
         in_rst = i_rst;                 // Settled since the falling edge
         @(negedge i_clk);
         if (in_rst) begin
            outstanding = 0;
         end else begin
            outstanding = outstanding + int'(beat_q) - int'(ret_q);
         end
         beat = (o_out_valid === 1'b1);
         if (beat && (outstanding >= `FE_CREDITS)) begin
            abort_run($sformatf("FAIL at %0t: output valid with all %0d credits in use",
                                $time, `FE_CREDITS));
         end
         credit_seed = lcg_step(credit_seed);
         draw        = credit_seed;
         ret_q       = 1'b0;
         if (gap > 0) begin
            gap--;
         end else if (draw[31:27] == 5'h1f) begin
            gap = 20 + draw[21:16];      // Long stall that drains all credits
         end else begin
            ret_q = (outstanding > 0) && draw[26];
         end
         i_credit_ret = ret_q;
         beat_q       = beat;
      end
   end

endmodule

//--- hdl/branch_resolve.sv
`include "mips_fe_cfg.svh"

module branch_resolve
   import mips_fe_pkg::*;
(
   input  pc_t       i_if_id_pc,     // Already pc+4
   input  word_t     i_if_id_instr,
   output reg_addr_t o_rs_addr,
   output reg_addr_t o_rt_addr,
   input  word_t     i_rs_data,
   input  word_t     i_rt_data,
   output logic      o_taken,
   output pc_t       o_target
);

   localparam int NB_IDX = `FE_NB_JMP - 2;           // J-type index width
   localparam int NB_SXT = `FE_NB_BITS - 18;         // Sign fill above imm<<2

   opcode_t           opcode;
   imm_t              imm;
   logic [NB_IDX-1:0] jmp_idx;
   logic              regs_eq;
   pc_t               br_offset;
   pc_t               br_target;
   pc_t               jmp_target;

   // Field split
   assign opcode    = i_if_id_instr[OPC_MSB:OPC_LSB];
   assign o_rs_addr = i_if_id_instr[RS_MSB:RS_LSB];
   assign o_rt_addr = i_if_id_instr[RT_MSB:RT_LSB];
   assign imm       = i_if_id_instr[IMM_MSB:0];
   assign jmp_idx   = i_if_id_instr[NB_IDX-1:0];

   assign regs_eq = (i_rs_data == i_rt_data);

   // Word offset, sign extended
   assign br_offset  = {{NB_SXT{imm[IMM_MSB]}}, imm, 2'b00};
   assign br_target  = i_if_id_pc + br_offset;

   // Region bits come from the delay-slot pc
   assign jmp_target = {i_if_id_pc[`FE_NB_BITS-1:`FE_NB_JMP], jmp_idx, 2'b00};

   always_comb begin
      o_taken  = 1'b0;
      o_target = br_target;
      case (opcode)
         OP_BEQ: begin
            o_taken = regs_eq;
         end
         OP_BNE: begin
            o_taken = !regs_eq;
         end
         OP_J: begin
            o_taken  = 1'b1;       // Unconditional
            o_target = jmp_target;
         end
         default: begin
            o_taken = 1'b0;        // ALU filler, NOP
         end
      endcase
   end

endmodule

//--- hdl/credit_tracker.sv
`include "mips_fe_cfg.svh"

module credit_tracker
   import mips_fe_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_valid,       // IF/ID holds an item
   input  logic i_credit_ret,  // One credit back per high cycle
   output logic o_issue
);

   credit_t credits;

   // Nothing leaves without a free slot downstream
   assign o_issue = i_valid && (credits != '0);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         credits <= credit_t'(`FE_CREDITS);
      end else begin
         case ({o_issue, i_credit_ret})
            2'b10:   credits <= credits - credit_t'(1);
            2'b01:   credits <= credits + credit_t'(1);
            default: credits <= credits;     // Idle or issue plus return
         endcase
      end
   end

endmodule

//--- hdl/fetch_stage.sv
`include "mips_fe_cfg.svh"

module fetch_stage
   import mips_fe_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_run,         // Low for program load
   input  logic       i_advance,     // Downstream took the IF/ID slot
   input  logic       i_taken,       // Redirect from decode
   input  pc_t        i_target,
   input  logic       i_load_en,
   input  imem_addr_t i_load_addr,
   input  word_t      i_load_data,
   output logic       o_if_id_valid,
   output pc_t        o_if_id_pc,
   output word_t      o_if_id_instr
);

   logic       advance;
   logic       redirect;
   logic       load_we;
   logic       ram_en;
   logic       squash;       // Slot in IF/ID was fetched on the wrong path
   logic       if_id_valid;
   pc_t        pc;
   pc_t        pc_plus4;
   pc_t        if_id_pc;
   imem_addr_t ram_addr;
   word_t      ram_data;     // RAM output reg doubles as IF/ID instr

   // Also fill an empty IF/ID on its own
   assign advance  = i_run && (i_advance || !if_id_valid);
   assign redirect = i_advance && i_taken;  // Only used under advance
   assign load_we  = i_load_en && !i_run;
   assign ram_en   = advance || load_we;
   assign pc_plus4 = pc + pc_t'(4);

   // Load port owns the address while stopped
   assign ram_addr = i_run ? pc[`FE_IMEM_DEPTH+1:2] : i_load_addr;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc          <= '0;
         if_id_valid <= 1'b0;
         squash      <= 1'b0;
      end else if (advance) begin
         pc          <= redirect ? i_target : pc_plus4;
         if_id_valid <= 1'b1;
         squash      <= redirect;  // Kill the slot read this cycle
      end
   end

   // IF/ID pc carries the fall-through address
   always_ff @(posedge i_clk) begin
      if (advance) begin
         if_id_pc <= pc_plus4;
      end
   end

   instr_mem instr_mem_i (
      .i_clk   (i_clk),
      .i_en    (ram_en),
      .i_addr  (ram_addr),
      .i_we    (load_we),
      .i_wdata (i_load_data),
      .o_data  (ram_data)
   );

   assign o_if_id_valid = if_id_valid;
   assign o_if_id_pc    = if_id_pc;
   assign o_if_id_instr = squash ? `FE_NOP_WORD : ram_data;  // Flush mux

endmodule

//--- hdl/instr_mem.sv
`include "mips_fe_cfg.svh"

module instr_mem
   import mips_fe_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_en,      // Port enable, gates read and write
   input  imem_addr_t i_addr,
   input  logic       i_we,
   input  word_t      i_wdata,
   output word_t      o_data
);

   localparam int NB_WORDS = 1 << `FE_IMEM_DEPTH;

   word_t mem [NB_WORDS];
   word_t rd_q;                  // Output latch, BRAM style

   // Read-first port
   always_ff @(posedge i_clk) begin
      if (i_en) begin
         if (i_we) begin
            mem[i_addr] <= i_wdata;
         end
         rd_q <= mem[i_addr];    // Old contents on a collision
      end
   end

   assign o_data = rd_q;         // Holds while i_en is low

endmodule

//--- hdl/mips_fe_cfg.svh
`ifndef MIPS_FE_CFG_SVH
`define MIPS_FE_CFG_SVH

// Datapath word width
`define FE_NB_BITS     32

// Jump field span as a byte address (26-bit index plus 2)
`define FE_NB_JMP      28

// Instruction memory address bits, in words
`define FE_IMEM_DEPTH  6

// Slots the downstream pipeline can accept before returning credits
`define FE_CREDITS     4

// sll $0,$0,0
`define FE_NOP_WORD    32'h0000_0000

`endif

//--- hdl/mips_fe_pkg.sv
`include "mips_fe_cfg.svh"

package mips_fe_pkg;

   // Instruction or register data
   typedef logic [`FE_NB_BITS-1:0]     word_t;

   // Byte address
   typedef logic [`FE_NB_BITS-1:0]     pc_t;

   // Word index into the instruction RAM
   typedef logic [`FE_IMEM_DEPTH-1:0]  imem_addr_t;

   typedef logic [4:0]                 reg_addr_t;   // $0..$31

   // Must hold 0 through FE_CREDITS inclusive
   typedef logic [$clog2(`FE_CREDITS+1)-1:0] credit_t;

   typedef logic [5:0]                 opcode_t;     // Instr[31:26]
   typedef logic [15:0]                imm_t;        // I-type immediate

   // Opcodes resolved in decode
   localparam opcode_t OP_J   = 6'h02;
   localparam opcode_t OP_BEQ = 6'h04;
   localparam opcode_t OP_BNE = 6'h05;

   // Field positions inside a word
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 26;
   localparam int RS_MSB  = 25;
   localparam int RS_LSB  = 21;
   localparam int RT_MSB  = 20;
   localparam int RT_LSB  = 16;
   localparam int IMM_MSB = 15;

endpackage

//--- hdl/mips_front_end.sv
module mips_front_end
   import mips_fe_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_run,
   // Program load, only while stopped
   input  logic       i_load_en,
   input  imem_addr_t i_load_addr,
   input  word_t      i_load_data,
   // Register write-back
   input  logic       i_wb_en,
   input  reg_addr_t  i_wb_addr,
   input  word_t      i_wb_data,
   // Downstream stream and credits
   input  logic       i_credit_ret,
   output logic       o_out_valid,
   output pc_t        o_out_pc,
   output word_t      o_out_instr
);

   logic      if_id_valid;
   pc_t       if_id_pc;
   word_t     if_id_instr;
   logic      issue;         // Item accepted this cycle
   logic      taken;
   pc_t       target;
   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   word_t     rs_data;
   word_t     rt_data;

   fetch_stage fetch_stage_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_run         (i_run),
      .i_advance     (issue),
      .i_taken       (taken),
      .i_target      (target),
      .i_load_en     (i_load_en),
      .i_load_addr   (i_load_addr),
      .i_load_data   (i_load_data),
      .o_if_id_valid (if_id_valid),
      .o_if_id_pc    (if_id_pc),
      .o_if_id_instr (if_id_instr)
   );

   branch_resolve branch_resolve_i (
      .i_if_id_pc    (if_id_pc),
      .i_if_id_instr (if_id_instr),
      .o_rs_addr     (rs_addr),
      .o_rt_addr     (rt_addr),
      .i_rs_data     (rs_data),
      .i_rt_data     (rt_data),
      .o_taken       (taken),
      .o_target      (target)
   );

   reg_file reg_file_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (i_wb_en),
      .i_waddr   (i_wb_addr),
      .i_wdata   (i_wb_data),
      .i_raddr_a (rs_addr),
      .i_raddr_b (rt_addr),
      .o_rdata_a (rs_data),
      .o_rdata_b (rt_data)
   );

   credit_tracker credit_tracker_i (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_valid      (if_id_valid),
      .i_credit_ret (i_credit_ret),
      .o_issue      (issue)
   );

   assign o_out_valid = issue;
   assign o_out_pc    = if_id_pc;     // pc+4 of the issued word
   assign o_out_instr = if_id_instr;  // NOP on a squashed slot

endmodule

//--- hdl/reg_file.sv
module reg_file
   import mips_fe_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_we,       // Write-back strobe
   input  reg_addr_t i_waddr,
   input  word_t     i_wdata,
   input  reg_addr_t i_raddr_a,  // rs
   input  reg_addr_t i_raddr_b,  // rt
   output word_t     o_rdata_a,
   output word_t     o_rdata_b
);

   word_t regs [32];

   // Single write port, driven only from write-back
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_waddr != '0)) begin  // $0 stays zero
         regs[i_waddr] <= i_wdata;
      end
   end

   // Combinational reads so the compare fits in decode
   always_comb begin
      if (i_raddr_a == '0) begin
         o_rdata_a = '0;
      end else begin
         o_rdata_a = regs[i_raddr_a];
      end
   end

   always_comb begin
      if (i_raddr_b == '0) begin
         o_rdata_b = '0;
      end else begin
         o_rdata_b = regs[i_raddr_b];
      end
   end

endmodule

//--- mips_front_end.f
+incdir+hdl
+incdir+bench
hdl/mips_fe_pkg.sv
hdl/instr_mem.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/branch_resolve.sv
hdl/credit_tracker.sv
hdl/mips_front_end.sv
bench/tb_mips_front_end.sv
